// File: hw/l1_dir_tag.sv
`timescale 1ns/1ps

module l1_dir_tag(
	input clk,
	input reset,
	input stall_i,
	input lookup_i,
	input [l2_cache_pkg::addr_width-1:0] address_i,
	input update_i,
	input [1:0] update_way_i,
	output logic has_line_o,
	output logic [1:0] way_o);

	import l2_cache_pkg::*;

	logic lookup_en;
	logic update_en;
	logic [l1_set_bits-1:0] lookup_set;
	logic [addr_width-1:0] addr_r;
	logic [l1_set_bits-1:0] cur_set;
	logic [l1_tag_bits-1:0] cur_tag;
	logic [l1_num_ways-1:0] update_mask;
	logic [l1_num_ways-1:0] valid_r [l1_num_sets];
	logic [l1_num_ways-1:0] valid_q;
	logic [l1_num_ways-1:0][l1_tag_bits-1:0] tag_q;
	logic [l1_num_ways-1:0] way_match;

	assign lookup_en = lookup_i && !stall_i;
	assign update_en = update_i && !stall_i;
	assign lookup_set = address_i[l1_set_bits-1:0];

	// Updates go to the line that was last looked up
	assign cur_set = addr_r[l1_set_bits-1:0];
	assign cur_tag = addr_r[addr_width-1:l1_set_bits];
	assign update_mask = l1_num_ways'(1) << update_way_i;

	genvar way;
	generate
		for (way = 0; way < l1_num_ways; way++)
		begin : gen_way
			sram_1r1w #(
				.word_t(logic [l1_tag_bits-1:0]),
				.depth(l1_num_sets),
				.addr_bits(l1_set_bits)
			) tag_mem(
				.clk(clk),
				.rd_en_i(lookup_en),
				.rd_addr_i(lookup_set),
				.rd_data_o(tag_q[way]),
				.wr_en_i(update_en && update_way_i == 2'(way)),
				.wr_addr_i(cur_set),
				.wr_data_i(cur_tag));
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < l1_num_sets; s++)
				valid_r[s] <= '0;
			valid_q <= '0;
		end
		else
		begin
			if (update_en)
				valid_r[cur_set] <= valid_r[cur_set] | update_mask;
			if (lookup_en)
			begin
				if (update_en && cur_set == lookup_set)
					valid_q <= valid_r[lookup_set] | update_mask;
				else
					valid_q <= valid_r[lookup_set];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (lookup_en)
			addr_r <= address_i;
	end

	// Lowest matching way is reported
	always_comb
	begin
		way_o = 2'd0;
		for (int w = l1_num_ways - 1; w >= 0; w--)
		begin
			way_match[w] = valid_q[w] && tag_q[w] == cur_tag;
			if (way_match[w])
				way_o = 2'(w);
		end
	end

	assign has_line_o = |way_match;

endmodule

// File: hw/l2_cache_dir.sv
`timescale 1ns/1ps

module l2_cache_dir(
	input clk,
	input reset,
	input stall_i,
	input tag_valid_i,
	input [1:0] tag_unit_i,
	input [1:0] tag_strand_i,
	input [2:0] tag_op_i,
	input [1:0] tag_way_i,
	input [l2_cache_pkg::addr_width-1:0] tag_address_i,
	input tag_has_sm_data_i,
	input [1:0] tag_replace_way_i,
	input [l2_cache_pkg::l2_num_ways-1:0][l2_cache_pkg::l2_tag_bits-1:0] tag_l2_tag_i,
	input [l2_cache_pkg::l2_num_ways-1:0] tag_l2_valid_i,
	output logic dir_valid_o,
	output logic [1:0] dir_unit_o,
	output logic [1:0] dir_strand_o,
	output logic [2:0] dir_op_o,
	output logic [1:0] dir_way_o,
	output logic [l2_cache_pkg::addr_width-1:0] dir_address_o,
	output logic dir_has_sm_data_o,
	output logic dir_cache_hit_o,
	output logic [1:0] dir_hit_way_o,
	output logic [1:0] dir_replace_way_o,
	output logic [l2_cache_pkg::l2_tag_bits-1:0] dir_old_tag_o,
	output logic [l2_cache_pkg::l2_num_ways-1:0] dir_dirty_o,
	output logic dir_l1_has_line_o,
	output logic [1:0] dir_l1_way_o);

	import l2_cache_pkg::*;

	logic lookup;
	logic [l2_tag_bits-1:0] req_tag;
	logic [l2_set_bits-1:0] req_set;
	logic [l2_num_ways-1:0] way_hit;
	logic cache_hit;
	logic [1:0] hit_way;
	logic [1:0] sel_way;
	logic [l2_num_ways-1:0] valid_q;
	logic [l2_num_ways-1:0] dirty_q;
	logic dir_is_load;
	logic dir_is_store;
	logic dir_is_flush;
	logic update_dirty;
	logic new_dirty;
	logic update_l1;

	assign lookup = tag_valid_i && !stall_i;
	assign req_tag = tag_address_i[addr_width-1:l2_set_bits];
	assign req_set = tag_address_i[l2_set_bits-1:0];

	// Lowest way wins if a line sits in two ways
	always_comb
	begin
		hit_way = 2'd0;
		for (int w = l2_num_ways - 1; w >= 0; w--)
		begin
			way_hit[w] = tag_l2_valid_i[w] && tag_l2_tag_i[w] == req_tag;
			if (way_hit[w])
				hit_way = 2'(w);
		end
	end

	assign cache_hit = |way_hit;
	assign sel_way = tag_has_sm_data_i ? tag_replace_way_i : hit_way;

	// Decode of the request held in this stage
	assign dir_is_load = dir_op_o == op_load || dir_op_o == op_load_sync;
	assign dir_is_store = dir_op_o == op_store || dir_op_o == op_store_sync;
	assign dir_is_flush = dir_op_o == op_flush;

	// Dirty bit commits as the request leaves this stage
	assign update_dirty = !stall_i && dir_valid_o
		&& (dir_has_sm_data_o || (dir_cache_hit_o && (dir_is_store || dir_is_flush)));

	// Fills mark only stores dirty while flush hits clear and store hits set
	assign new_dirty = dir_has_sm_data_o ? dir_is_store : !dir_is_flush;

	// Line about to be pushed into the L1 data cache
	assign update_l1 = dir_valid_o && dir_is_load && dir_unit_o == unit_dcache
		&& (dir_cache_hit_o || dir_has_sm_data_o);

	genvar way;
	generate
		for (way = 0; way < l2_num_ways; way++)
		begin : gen_way
			sram_1r1w #(
				.word_t(logic),
				.depth(l2_num_sets),
				.addr_bits(l2_set_bits)
			) dirty_mem(
				.clk(clk),
				.rd_en_i(lookup),
				.rd_addr_i(req_set),
				.rd_data_o(dirty_q[way]),
				.wr_en_i(update_dirty && dir_hit_way_o == 2'(way)),
				.wr_addr_i(dir_address_o[l2_set_bits-1:0]),
				.wr_data_i(new_dirty));
		end
	endgenerate

	assign dir_dirty_o = dirty_q & valid_q;

	l1_dir_tag l1_dir_tag_i(
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.lookup_i(tag_valid_i),
		.address_i(tag_address_i),
		.update_i(update_l1),
		.update_way_i(dir_way_o),
		.has_line_o(dir_l1_has_line_o),
		.way_o(dir_l1_way_o));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			dir_valid_o <= 1'b0;
			dir_cache_hit_o <= 1'b0;
			valid_q <= '0;
		end
		else if (!stall_i)
		begin
			dir_valid_o <= tag_valid_i;
			if (tag_valid_i)
			begin
				dir_cache_hit_o <= cache_hit;
				valid_q <= tag_l2_valid_i;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (lookup)
		begin
			dir_unit_o <= tag_unit_i;
			dir_strand_o <= tag_strand_i;
			dir_op_o <= tag_op_i;
			dir_way_o <= tag_way_i;
			dir_address_o <= tag_address_i;
			dir_has_sm_data_o <= tag_has_sm_data_i;
			dir_hit_way_o <= sel_way;
			dir_replace_way_o <= tag_replace_way_i;
			dir_old_tag_o <= tag_l2_tag_i[sel_way];
		end
	end

endmodule

// File: hw/l2_cache_front.sv
`timescale 1ns/1ps

module l2_cache_front(
	input clk,
	input reset,
	input stall_i,
	input req_valid_i,
	input [1:0] req_unit_i,
	input [1:0] req_strand_i,
	input [2:0] req_op_i,
	input [1:0] req_way_i,
	input [l2_cache_pkg::addr_width-1:0] req_address_i,
	input req_has_sm_data_i,
	output logic dir_valid_o,
	output logic [1:0] dir_unit_o,
	output logic [1:0] dir_strand_o,
	output logic [2:0] dir_op_o,
	output logic [1:0] dir_way_o,
	output logic [l2_cache_pkg::addr_width-1:0] dir_address_o,
	output logic dir_has_sm_data_o,
	output logic dir_cache_hit_o,
	output logic [1:0] dir_hit_way_o,
	output logic [1:0] dir_replace_way_o,
	output logic [l2_cache_pkg::l2_tag_bits-1:0] dir_old_tag_o,
	output logic [l2_cache_pkg::l2_num_ways-1:0] dir_dirty_o,
	output logic dir_l1_has_line_o,
	output logic [1:0] dir_l1_way_o);

	import l2_cache_pkg::*;

	logic tag_valid;
	logic [1:0] tag_unit;
	logic [1:0] tag_strand;
	logic [2:0] tag_op;
	logic [1:0] tag_way;
	logic [addr_width-1:0] tag_address;
	logic tag_has_sm_data;
	logic [1:0] tag_replace_way;
	logic [l2_tag_bits-1:0] tag_l2_tag0;
	logic [l2_tag_bits-1:0] tag_l2_tag1;
	logic [l2_tag_bits-1:0] tag_l2_tag2;
	logic [l2_tag_bits-1:0] tag_l2_tag3;
	logic tag_l2_valid0;
	logic tag_l2_valid1;
	logic tag_l2_valid2;
	logic tag_l2_valid3;

	l2_cache_tag l2_cache_tag_i(
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.req_valid_i(req_valid_i),
		.req_unit_i(req_unit_i),
		.req_strand_i(req_strand_i),
		.req_op_i(req_op_i),
		.req_way_i(req_way_i),
		.req_address_i(req_address_i),
		.req_has_sm_data_i(req_has_sm_data_i),
		.tag_valid_o(tag_valid),
		.tag_unit_o(tag_unit),
		.tag_strand_o(tag_strand),
		.tag_op_o(tag_op),
		.tag_way_o(tag_way),
		.tag_address_o(tag_address),
		.tag_has_sm_data_o(tag_has_sm_data),
		.tag_replace_way_o(tag_replace_way),
		.tag_l2_tag_o({tag_l2_tag3, tag_l2_tag2, tag_l2_tag1, tag_l2_tag0}),
		.tag_l2_valid_o({tag_l2_valid3, tag_l2_valid2, tag_l2_valid1, tag_l2_valid0}));

	l2_cache_dir l2_cache_dir_i(
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.tag_valid_i(tag_valid),
		.tag_unit_i(tag_unit),
		.tag_strand_i(tag_strand),
		.tag_op_i(tag_op),
		.tag_way_i(tag_way),
		.tag_address_i(tag_address),
		.tag_has_sm_data_i(tag_has_sm_data),
		.tag_replace_way_i(tag_replace_way),
		.tag_l2_tag_i({tag_l2_tag3, tag_l2_tag2, tag_l2_tag1, tag_l2_tag0}),
		.tag_l2_valid_i({tag_l2_valid3, tag_l2_valid2, tag_l2_valid1, tag_l2_valid0}),
		.dir_valid_o(dir_valid_o),
		.dir_unit_o(dir_unit_o),
		.dir_strand_o(dir_strand_o),
		.dir_op_o(dir_op_o),
		.dir_way_o(dir_way_o),
		.dir_address_o(dir_address_o),
		.dir_has_sm_data_o(dir_has_sm_data_o),
		.dir_cache_hit_o(dir_cache_hit_o),
		.dir_hit_way_o(dir_hit_way_o),
		.dir_replace_way_o(dir_replace_way_o),
		.dir_old_tag_o(dir_old_tag_o),
		.dir_dirty_o(dir_dirty_o),
		.dir_l1_has_line_o(dir_l1_has_line_o),
		.dir_l1_way_o(dir_l1_way_o));

endmodule

// File: hw/l2_cache_pkg.sv
package l2_cache_pkg;

	// Line address counted in 64 byte lines
	localparam int addr_width = 26;

	// L2 geometry
	localparam int l2_num_ways = 4;
	localparam int l2_set_bits = 4;
	localparam int l2_num_sets = 16;
	localparam int l2_tag_bits = addr_width - l2_set_bits;

	// L1 data cache geometry mirrored by the directory
	localparam int l1_set_bits = 3;
	localparam int l1_num_sets = 8;
	localparam int l1_tag_bits = addr_width - l1_set_bits;
	localparam int l1_num_ways = 4;

	// Request operations
	localparam logic [2:0] op_load = 3'd0;
	localparam logic [2:0] op_store = 3'd1;
	localparam logic [2:0] op_flush = 3'd2;
	localparam logic [2:0] op_load_sync = 3'd4;
	localparam logic [2:0] op_store_sync = 3'd5;

	// Requesting units
	localparam logic [1:0] unit_icache = 2'd0;
	localparam logic [1:0] unit_dcache = 2'd1;
	localparam logic [1:0] unit_stbuf = 2'd2;

endpackage

// File: hw/l2_cache_tag.sv
`timescale 1ns/1ps

module l2_cache_tag(
	input clk,
	input reset,
	input stall_i,
	input req_valid_i,
	input [1:0] req_unit_i,
	input [1:0] req_strand_i,
	input [2:0] req_op_i,
	input [1:0] req_way_i,
	input [l2_cache_pkg::addr_width-1:0] req_address_i,
	input req_has_sm_data_i,
	output logic tag_valid_o,
	output logic [1:0] tag_unit_o,
	output logic [1:0] tag_strand_o,
	output logic [2:0] tag_op_o,
	output logic [1:0] tag_way_o,
	output logic [l2_cache_pkg::addr_width-1:0] tag_address_o,
	output logic tag_has_sm_data_o,
	output logic [1:0] tag_replace_way_o,
	output logic [l2_cache_pkg::l2_num_ways-1:0][l2_cache_pkg::l2_tag_bits-1:0] tag_l2_tag_o,
	output logic [l2_cache_pkg::l2_num_ways-1:0] tag_l2_valid_o);

	import l2_cache_pkg::*;

	logic [l2_num_ways-1:0] valid_r [l2_num_sets];
	logic [1:0] victim_r [l2_num_sets];
	logic accept;
	logic fill_en;
	logic fill_same_set;
	logic [l2_set_bits-1:0] req_set;
	logic [l2_set_bits-1:0] fill_set;
	logic [l2_tag_bits-1:0] fill_tag;
	logic [l2_num_ways-1:0] fill_way_mask;

	assign accept = req_valid_i && !stall_i;
	assign req_set = req_address_i[l2_set_bits-1:0];

	// The fill in this stage commits as it moves on
	assign fill_en = tag_valid_o && tag_has_sm_data_o && !stall_i;
	assign fill_set = tag_address_o[l2_set_bits-1:0];
	assign fill_tag = tag_address_o[addr_width-1:l2_set_bits];
	assign fill_way_mask = l2_num_ways'(1) << tag_replace_way_o;

	// Incoming request reads the set being filled on the same edge
	assign fill_same_set = fill_en && fill_set == req_set;

	genvar way;
	generate
		for (way = 0; way < l2_num_ways; way++)
		begin : gen_way
			sram_1r1w #(
				.word_t(logic [l2_tag_bits-1:0]),
				.depth(l2_num_sets),
				.addr_bits(l2_set_bits)
			) tag_mem(
				.clk(clk),
				.rd_en_i(accept),
				.rd_addr_i(req_set),
				.rd_data_o(tag_l2_tag_o[way]),
				.wr_en_i(fill_en && tag_replace_way_o == 2'(way)),
				.wr_addr_i(fill_set),
				.wr_data_i(fill_tag));
		end
	endgenerate

	// Valid bits and round-robin victim pointer per set
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < l2_num_sets; s++)
			begin
				valid_r[s] <= '0;
				victim_r[s] <= '0;
			end
		end
		else if (fill_en)
		begin
			valid_r[fill_set] <= valid_r[fill_set] | fill_way_mask;
			victim_r[fill_set] <= tag_replace_way_o + 2'd1;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			tag_valid_o <= 1'b0;
			tag_l2_valid_o <= '0;
			tag_replace_way_o <= 2'd0;
		end
		else if (!stall_i)
		begin
			tag_valid_o <= req_valid_i;
			if (req_valid_i)
			begin
				if (fill_same_set)
				begin
					tag_l2_valid_o <= valid_r[req_set] | fill_way_mask;
					tag_replace_way_o <= tag_replace_way_o + 2'd1;
				end
				else
				begin
					tag_l2_valid_o <= valid_r[req_set];
					tag_replace_way_o <= victim_r[req_set];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			tag_unit_o <= req_unit_i;
			tag_strand_o <= req_strand_i;
			tag_op_o <= req_op_i;
			tag_way_o <= req_way_i;
			tag_address_o <= req_address_i;
			tag_has_sm_data_o <= req_has_sm_data_i;
		end
	end

endmodule

// File: hw/sram_1r1w.sv
`timescale 1ns/1ps

module sram_1r1w
	#(
		parameter type word_t = logic,
		parameter int depth = 16,
		parameter int addr_bits = 4
	)
	(
		input clk,
		input rd_en_i,
		input [addr_bits-1:0] rd_addr_i,
		output word_t rd_data_o,
		input wr_en_i,
		input [addr_bits-1:0] wr_addr_i,
		input word_t wr_data_i
	);

	word_t mem [depth];

	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;

		// Read output holds while rd_en_i is low
		if (rd_en_i)
		begin
			// A write on the same edge wins over the stored word
			if (wr_en_i && wr_addr_i == rd_addr_i)
				rd_data_o <= wr_data_i;
			else
				rd_data_o <= mem[rd_addr_i];
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build the L2 front testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing -f tb.f --top-module tb_l2_front \
	&& ./obj_dir/Vtb_l2_front | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb.f
+incdir+test
hw/l2_cache_pkg.sv
hw/sram_1r1w.sv
hw/l2_cache_tag.sv
hw/l1_dir_tag.sv
hw/l2_cache_dir.sv
hw/l2_cache_front.sv
test/tb_l2_front.sv

// File: test/l2_front_model.svh
`ifndef L2_FRONT_MODEL_SVH
`define L2_FRONT_MODEL_SVH

// Expected result of one request with the edge index where it was accepted
typedef struct packed {
	logic [1:0] unit;
	logic [1:0] strand;
	logic [2:0] op;
	logic [1:0] way;
	logic [addr_width-1:0] address;
	logic has_sm_data;
	logic cache_hit;
	logic [1:0] hit_way;
	logic [1:0] replace_way;
	logic check_old_tag;
	logic [l2_tag_bits-1:0] old_tag;
	logic [l2_num_ways-1:0] dirty;
	logic l1_has_line;
	logic [1:0] l1_way;
	logic [31:0] accept_edge;
} expect_t;

logic [l2_tag_bits-1:0] l2_tag_state [l2_num_sets][l2_num_ways];
logic [l2_num_ways-1:0] l2_valid_state [l2_num_sets];
logic [l2_num_ways-1:0] l2_dirty_state [l2_num_sets];
logic [1:0] l2_victim_state [l2_num_sets];
logic [l1_tag_bits-1:0] l1_tag_state [l1_num_sets][l1_num_ways];
logic [l1_num_ways-1:0] l1_valid_state [l1_num_sets];

function automatic void reset_model();
	for (int s = 0; s < l2_num_sets; s++)
	begin
		l2_valid_state[s] = '0;
		l2_dirty_state[s] = '0;
		l2_victim_state[s] = 2'd0;
		for (int w = 0; w < l2_num_ways; w++)
			l2_tag_state[s][w] = '0;
	end
	for (int s = 0; s < l1_num_sets; s++)
	begin
		l1_valid_state[s] = '0;
		for (int w = 0; w < l1_num_ways; w++)
			l1_tag_state[s][w] = '0;
	end
endfunction

// L2 way that holds the line or -1 on a miss
function automatic int l2_find(input logic [addr_width-1:0] address);
	int found;
	logic [l2_set_bits-1:0] set;
	found = -1;
	set = address[l2_set_bits-1:0];
	for (int w = l2_num_ways - 1; w >= 0; w--)
	begin
		if (l2_valid_state[set][w] && l2_tag_state[set][w] == address[addr_width-1:l2_set_bits])
			found = w;
	end
	return found;
endfunction

// L1 way that holds the line or -1 if the L1 lacks it
function automatic int l1_find(input logic [addr_width-1:0] address);
	int found;
	logic [l1_set_bits-1:0] set;
	found = -1;
	set = address[l1_set_bits-1:0];
	for (int w = l1_num_ways - 1; w >= 0; w--)
	begin
		if (l1_valid_state[set][w] && l1_tag_state[set][w] == address[addr_width-1:l1_set_bits])
			found = w;
	end
	return found;
endfunction

function automatic expect_t predict_request(input logic [1:0] unit, input logic [1:0] strand,
	input logic [2:0] op, input logic [1:0] way, input logic [addr_width-1:0] address,
	input logic has_sm_data);
	expect_t entry;
	logic [l2_set_bits-1:0] set;
	logic [l1_set_bits-1:0] l1_set;
	logic [1:0] sel_way;
	logic is_load;
	logic is_store;
	int hit;
	int l1_way;
	set = address[l2_set_bits-1:0];
	l1_set = address[l1_set_bits-1:0];
	hit = l2_find(address);
	l1_way = l1_find(address);
	is_load = op == op_load || op == op_load_sync;
	is_store = op == op_store || op == op_store_sync;
	sel_way = has_sm_data ? l2_victim_state[set] : 2'(hit);

	// Results show the state before this request
	entry = '0;
	entry.unit = unit;
	entry.strand = strand;
	entry.op = op;
	entry.way = way;
	entry.address = address;
	entry.has_sm_data = has_sm_data;
	entry.cache_hit = hit >= 0;
	entry.hit_way = sel_way;
	entry.replace_way = l2_victim_state[set];
	entry.check_old_tag = has_sm_data ? l2_valid_state[set][sel_way] : hit >= 0;
	entry.old_tag = l2_tag_state[set][sel_way];
	entry.dirty = l2_dirty_state[set] & l2_valid_state[set];
	entry.l1_has_line = l1_way >= 0;
	entry.l1_way = 2'(l1_way);

	// Fill installs the line in the victim way and moves the pointer on
	if (has_sm_data)
	begin
		l2_tag_state[set][sel_way] = address[addr_width-1:l2_set_bits];
		l2_valid_state[set][sel_way] = 1'b1;
		l2_victim_state[set] = l2_victim_state[set] + 2'd1;
		l2_dirty_state[set][sel_way] = is_store;
	end
	else if (hit >= 0 && (is_store || op == op_flush))
		l2_dirty_state[set][sel_way] = is_store;

	// Line pushed into the L1 data cache
	if (is_load && unit == unit_dcache && (hit >= 0 || has_sm_data))
	begin
		l1_tag_state[l1_set][way] = address[addr_width-1:l1_set_bits];
		l1_valid_state[l1_set][way] = 1'b1;
	end
	return entry;
endfunction

`endif

// File: test/tb_l2_front.sv
`timescale 1ns/1ps

module tb_l2_front;

	import l2_cache_pkg::*;

	logic clk;
	logic reset;
	logic stall;
	logic req_valid;
	logic [1:0] req_unit;
	logic [1:0] req_strand;
	logic [2:0] req_op;
	logic [1:0] req_way;
	logic [addr_width-1:0] req_address;
	logic req_has_sm_data;
	logic dir_valid;
	logic [1:0] dir_unit;
	logic [1:0] dir_strand;
	logic [2:0] dir_op;
	logic [1:0] dir_way;
	logic [addr_width-1:0] dir_address;
	logic dir_has_sm_data;
	logic dir_cache_hit;
	logic [1:0] dir_hit_way;
	logic [1:0] dir_replace_way;
	logic [l2_tag_bits-1:0] dir_old_tag;
	logic [l2_num_ways-1:0] dir_dirty;
	logic dir_l1_has_line;
	logic [1:0] dir_l1_way;

	int seed;
	int error_count;
	int check_count;
	int test_count;
	int edge_count;
	logic timed_out;
	string test_name;
	logic [addr_width-1:0] addr_pool [18];

	`include "l2_front_model.svh"

	expect_t expect_queue[$];

	l2_cache_front l2_cache_front_i(
		.clk(clk),
		.reset(reset),
		.stall_i(stall),
		.req_valid_i(req_valid),
		.req_unit_i(req_unit),
		.req_strand_i(req_strand),
		.req_op_i(req_op),
		.req_way_i(req_way),
		.req_address_i(req_address),
		.req_has_sm_data_i(req_has_sm_data),
		.dir_valid_o(dir_valid),
		.dir_unit_o(dir_unit),
		.dir_strand_o(dir_strand),
		.dir_op_o(dir_op),
		.dir_way_o(dir_way),
		.dir_address_o(dir_address),
		.dir_has_sm_data_o(dir_has_sm_data),
		.dir_cache_hit_o(dir_cache_hit),
		.dir_hit_way_o(dir_hit_way),
		.dir_replace_way_o(dir_replace_way),
		.dir_old_tag_o(dir_old_tag),
		.dir_dirty_o(dir_dirty),
		.dir_l1_has_line_o(dir_l1_has_line),
		.dir_l1_way_o(dir_l1_way));

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	function automatic int rand_below(input int limit);
		return {$random(seed)} % limit;
	endfunction

	function automatic logic [2:0] random_op();
		case (rand_below(5))
			0: return op_load;
			1: return op_load_sync;
			2: return op_store;
			3: return op_store_sync;
			default: return op_flush;
		endcase
	endfunction

	task automatic check_value(input string field, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("error %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
		end
	endtask

	task automatic check_output();
		expect_t entry;
		if (expect_queue.size() == 0)
		begin
			error_count++;
			$display("%s: the DUT gave a result while no request was pending", test_name);
		end
		else
		begin
			entry = expect_queue.pop_front();
			// Leaves on the second unstalled edge after acceptance
			check_value("output edge", 64'(entry.accept_edge + 2), 64'(edge_count));
			check_value("unit", 64'(entry.unit), 64'(dir_unit));
			check_value("strand", 64'(entry.strand), 64'(dir_strand));
			check_value("op", 64'(entry.op), 64'(dir_op));
			check_value("way", 64'(entry.way), 64'(dir_way));
			check_value("address", 64'(entry.address), 64'(dir_address));
			check_value("has_sm_data", 64'(entry.has_sm_data), 64'(dir_has_sm_data));
			check_value("cache_hit", 64'(entry.cache_hit), 64'(dir_cache_hit));
			if (entry.cache_hit || entry.has_sm_data)
				check_value("hit_way", 64'(entry.hit_way), 64'(dir_hit_way));
			check_value("replace_way", 64'(entry.replace_way), 64'(dir_replace_way));
			if (entry.check_old_tag)
				check_value("old_tag", 64'(entry.old_tag), 64'(dir_old_tag));
			check_value("dirty", 64'(entry.dirty), 64'(dir_dirty));
			check_value("l1_has_line", 64'(entry.l1_has_line), 64'(dir_l1_has_line));
			if (entry.l1_has_line)
				check_value("l1_way", 64'(entry.l1_way), 64'(dir_l1_way));
		end
	endtask

	task automatic record_request();
		expect_t entry;
		entry = predict_request(req_unit, req_strand, req_op, req_way, req_address,
			req_has_sm_data);
		entry.accept_edge = edge_count;
		expect_queue.push_back(entry);
	endtask

	// Inputs only change 1 ns after a rising edge, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (!reset && !stall)
		begin
			edge_count++;
			if (dir_valid)
				check_output();
			if (req_valid)
				record_request();
		end
	end

	// Hold one request until an unstalled edge takes it
	task automatic send_request(input logic [1:0] unit, input logic [2:0] op,
		input logic [1:0] way, input logic [addr_width-1:0] address,
		input logic has_sm_data, input int stall_pct);
		int tries;
		logic accepted;
		req_valid = 1'b1;
		req_unit = unit;
		req_strand = 2'(rand_below(4));
		req_op = op;
		req_way = way;
		req_address = address;
		req_has_sm_data = has_sm_data;
		tries = 0;
		accepted = 1'b0;
		while (!accepted && !timed_out)
		begin
			stall = rand_below(100) < stall_pct;
			@(posedge clk);
			accepted = !stall;
			#1;
			tries++;
			if (!accepted && tries == 40)
			begin
				timed_out = 1'b1;
				error_count++;
				$display("%s: a request was not accepted within 40 cycles", test_name);
			end
		end
		req_valid = 1'b0;
		stall = 1'b0;
	endtask

	task automatic idle_cycles(input int count, input int stall_pct);
		req_valid = 1'b0;
		for (int i = 0; i < count; i++)
		begin
			stall = rand_below(100) < stall_pct;
			@(posedge clk);
			#1;
		end
		stall = 1'b0;
	endtask

	task automatic drain_pipeline();
		int cycles;
		req_valid = 1'b0;
		stall = 1'b0;
		cycles = 0;
		while (expect_queue.size() != 0 && !timed_out)
		begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles == 20)
			begin
				timed_out = 1'b1;
				error_count++;
				$display("%s: %0d results never came out of the pipeline", test_name,
					expect_queue.size());
			end
		end
	endtask

	task automatic finish_test(input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("test %s passed", test_name);
		else
			$display("test %s failed with %0d errors", test_name, error_count - errors_before);
	endtask

	initial
	begin
		int errors_before;
		int found;
		logic [1:0] unit;
		logic [1:0] way;
		logic [2:0] op;
		logic fill;
		logic [addr_width-1:0] address;
		logic [addr_width-1:0] line_a;
		logic [addr_width-1:0] line_b;
		logic [addr_width-1:0] line_c;
		logic [addr_width-1:0] line_d;
		logic [addr_width-1:0] line_e;

		seed = 96;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		edge_count = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		stall = 1'b0;
		req_valid = 1'b0;
		req_unit = unit_icache;
		req_strand = 2'd0;
		req_op = op_load;
		req_way = 2'd0;
		req_address = '0;
		req_has_sm_data = 1'b0;
		reset_model();

		// Six tags in each of L2 sets 3, 7 and 11 so that fills evict
		// Sets 3 and 11 share an L1 set
		for (int i = 0; i < 18; i++)
			addr_pool[i] = {l2_tag_bits'(i / 3 * 4099 + 17), l2_set_bits'(i % 3 * 4 + 3)};
		line_a = {22'h000a11, 4'h5};
		line_b = {22'h001b22, 4'h5};
		line_c = {22'h002c33, 4'h5};
		line_d = {22'h003d44, 4'h5};
		line_e = {22'h004e55, 4'h5};

		repeat (2)
			@(posedge clk);
		#1;
		reset = 1'b0;

		test_name = "reset_state";
		errors_before = error_count;
		check_value("valid", 64'd0, 64'(dir_valid));
		check_value("cache_hit", 64'd0, 64'(dir_cache_hit));
		check_value("l1_has_line", 64'd0, 64'(dir_l1_has_line));
		check_value("dirty", 64'd0, 64'(dir_dirty));
		for (int i = 0; i < 18; i++)
			send_request(unit_dcache, op_store, 2'd0, addr_pool[i], 1'b0, 0);
		drain_pipeline();
		finish_test(errors_before);

		// Back to back requests in one set exercise every forwarding path
		test_name = "directed";
		errors_before = error_count;
		send_request(unit_stbuf, op_store, 2'd0, line_a, 1'b1, 0);
		send_request(unit_dcache, op_load, 2'd1, line_a, 1'b0, 0);
		send_request(unit_dcache, op_store, 2'd0, line_a, 1'b0, 0);
		send_request(unit_icache, op_load, 2'd0, line_b, 1'b1, 0);
		send_request(unit_icache, op_load, 2'd2, line_b, 1'b0, 0);
		send_request(unit_stbuf, op_store, 2'd0, line_b, 1'b0, 0);
		send_request(unit_dcache, op_flush, 2'd0, line_a, 1'b0, 0);
		send_request(unit_dcache, op_load, 2'd0, line_c, 1'b1, 0);
		send_request(unit_stbuf, op_store_sync, 2'd0, line_d, 1'b1, 0);
		send_request(unit_dcache, op_load, 2'd0, line_e, 1'b1, 0);
		send_request(unit_dcache, op_load_sync, 2'd3, line_e, 1'b0, 0);
		send_request(unit_stbuf, op_store_sync, 2'd0, line_e, 1'b0, 0);
		send_request(unit_dcache, op_load, 2'd2, line_a, 1'b0, 0);
		drain_pipeline();
		finish_test(errors_before);

		test_name = "random";
		errors_before = error_count;
		for (int n = 0; n < 400 && !timed_out; n++)
		begin
			address = addr_pool[rand_below(18)];
			op = random_op();
			unit = 2'(rand_below(3));
			way = 2'(rand_below(4));
			// A fill only brings in a line that the L2 lacks
			fill = rand_below(4) == 0 && l2_find(address) < 0;
			found = l1_find(address);
			if (found >= 0)
				way = 2'(found);
			send_request(unit, op, way, address, fill, 25);
			if (rand_below(4) == 0)
				idle_cycles(rand_below(3) + 1, 25);
		end
		drain_pipeline();
		finish_test(errors_before);

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
